// ==== mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath and address width
`define MIPS_XLEN 32

// register file depth
`define MIPS_REGS 32

// direct-mapped cache, one word per line
`define MIPS_CACHE_LINES 8
`define MIPS_INDEX_W 3

// byte offset inside a word
`define MIPS_OFFSET_W 2

// tag takes every address bit above index and offset
`define MIPS_TAG_W (`MIPS_XLEN - `MIPS_INDEX_W - `MIPS_OFFSET_W)

`define MIPS_OP_HALT 6'h3f

`endif

// ==== mips_pkg.sv ====
`include "mips_config.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b,
        op_halt  = `MIPS_OP_HALT
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_inst_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_inst_t;

    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_u;

endpackage

// ==== control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
    input  mips_pkg::inst_u   inst,
    output mips_pkg::alu_op_e alu_op,
    output logic              alu_src,
    output logic              reg_dest,
    output logic              reg_write,
    output logic              mem_to_reg,
    output logic              branch_eq,
    output logic              branch_ne,
    output logic              jump,
    output logic              mem_read,
    output logic              mem_write,
    output logic              halt
);

    localparam logic [5:0] funct_add = 6'h20;
    localparam logic [5:0] funct_sub = 6'h22;
    localparam logic [5:0] funct_and = 6'h24;
    localparam logic [5:0] funct_or  = 6'h25;
    localparam logic [5:0] funct_slt = 6'h2a;

    always_comb begin
        alu_op     = mips_pkg::alu_add;
        alu_src    = 1'b0;
        reg_dest   = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        branch_eq  = 1'b0;
        branch_ne  = 1'b0;
        jump       = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        halt       = 1'b0;
        case (inst.r.opcode)
            mips_pkg::op_rtype: begin
                reg_dest  = 1'b1;
                reg_write = 1'b1;
                case (inst.r.funct)
                    funct_add: alu_op = mips_pkg::alu_add;
                    funct_sub: alu_op = mips_pkg::alu_sub;
                    funct_and: alu_op = mips_pkg::alu_and;
                    funct_or:  alu_op = mips_pkg::alu_or;
                    funct_slt: alu_op = mips_pkg::alu_slt;
                    default:   reg_write = 1'b0; // unsupported funct is a no-op
                endcase
            end
            mips_pkg::op_addi: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::op_lw: begin
                alu_src    = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
            end
            mips_pkg::op_sw: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            mips_pkg::op_beq: begin
                alu_op    = mips_pkg::alu_sub; // zero flag means equal
                branch_eq = 1'b1;
            end
            mips_pkg::op_bne: begin
                alu_op    = mips_pkg::alu_sub;
                branch_ne = 1'b1;
            end
            mips_pkg::op_j:    jump = 1'b1;
            mips_pkg::op_halt: halt = 1'b1;
            default: ; // unknown opcode, nothing happens
        endcase
    end

    always_comb begin
        assert (!(mem_read && mem_write))
            else $error("load and store decoded for the same instruction");
    end

endmodule

// ==== data_path.sv ====
`timescale 1ns/100ps
`include "mips_config.svh"

module data_path (
    input  logic                  clk,
    input  logic                  reset,
    input  mips_pkg::inst_u       inst,
    input  mips_pkg::alu_op_e     alu_op,
    input  logic                  alu_src,
    input  logic                  reg_dest,
    input  logic                  reg_write,
    input  logic                  mem_to_reg,
    input  logic                  branch_eq,
    input  logic                  branch_ne,
    input  logic                  jump,
    input  logic                  halt,
    input  logic                  stall,
    input  logic [`MIPS_XLEN-1:0] load_data,
    output logic [`MIPS_XLEN-1:0] inst_addr,
    output logic [`MIPS_XLEN-1:0] alu_result,
    output logic [`MIPS_XLEN-1:0] store_data,
    output logic                  halted
);

    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] jump_target;
    logic [`MIPS_XLEN-1:0] next_pc;
    logic [`MIPS_XLEN-1:0] regs [`MIPS_REGS];
    logic [`MIPS_XLEN-1:0] rs_val;
    logic [`MIPS_XLEN-1:0] rt_val;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] alu_b;
    logic [`MIPS_XLEN-1:0] wr_data;
    logic [4:0]            wr_reg;
    logic                  zero;
    logic                  take_branch;
    logic                  advance;

    assign inst_addr = pc;

    // r0 is hardwired to zero
    assign rs_val = (inst.i.rs == 5'd0) ? '0 : regs[inst.i.rs];
    assign rt_val = (inst.i.rt == 5'd0) ? '0 : regs[inst.i.rt];
    assign store_data = rt_val;

    assign imm_ext = {{(`MIPS_XLEN-16){inst.i.imm[15]}}, inst.i.imm};
    assign alu_b   = alu_src ? imm_ext : rt_val;

    always_comb begin
        case (alu_op)
            mips_pkg::alu_add: alu_result = rs_val + alu_b;
            mips_pkg::alu_sub: alu_result = rs_val - alu_b;
            mips_pkg::alu_and: alu_result = rs_val & alu_b;
            mips_pkg::alu_or:  alu_result = rs_val | alu_b;
            mips_pkg::alu_slt:
                alu_result = {{(`MIPS_XLEN-1){1'b0}}, $signed(rs_val) < $signed(alu_b)};
            default:           alu_result = rs_val + alu_b;
        endcase
    end

    assign zero = (alu_result == '0);

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
    // 26-bit target spans rs, rt and imm of the i view
    assign jump_target   = {pc_plus4[31:28], inst.i.rs, inst.i.rt, inst.i.imm, 2'b00};
    assign take_branch   = (branch_eq && zero) || (branch_ne && !zero);

    always_comb begin
        if (jump)
            next_pc = jump_target;
        else if (take_branch)
            next_pc = branch_target;
        else
            next_pc = pc_plus4;
    end

    assign wr_reg  = reg_dest ? inst.r.rd : inst.i.rt;
    assign wr_data = mem_to_reg ? load_data : alu_result;
    assign advance = !stall && !halted; // frozen on cache miss or after halt

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (advance) begin
            if (halt)
                halted <= 1'b1; // pc stays on the halt word
            else
                pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && reg_write && wr_reg != 5'd0)
            regs[wr_reg] <= wr_data;
    end

    a_pc_frozen_after_halt: assert property (
        @(posedge clk) disable iff (reset) halted |=> $stable(inst_addr)
    ) else $error("instruction address moved after halt");

endmodule

// ==== memory_datapath.sv ====
`timescale 1ns/100ps
`include "mips_config.svh"

module memory_datapath (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`MIPS_XLEN-1:0] addr,
    input  logic [`MIPS_XLEN-1:0] store_data,
    input  logic                  mem_write,
    input  logic                  cache_fill,
    input  logic                  cache_store,
    input  logic [`MIPS_XLEN-1:0] mem_rdata,
    output logic [`MIPS_XLEN-1:0] load_data,
    output logic                  hit,
    output logic                  dirty,
    output logic [`MIPS_XLEN-1:0] wb_addr,
    output logic [`MIPS_XLEN-1:0] wb_data
);

    logic [`MIPS_XLEN-1:0]        data_array [`MIPS_CACHE_LINES];
    logic [`MIPS_TAG_W-1:0]       tag_array  [`MIPS_CACHE_LINES];
    logic [`MIPS_CACHE_LINES-1:0] valid_bits;
    logic [`MIPS_CACHE_LINES-1:0] dirty_bits;
    logic [`MIPS_INDEX_W-1:0]     index;
    logic [`MIPS_TAG_W-1:0]       tag;
    logic                         store_en;

    assign index = addr[`MIPS_OFFSET_W +: `MIPS_INDEX_W];
    assign tag   = addr[`MIPS_XLEN-1 -: `MIPS_TAG_W];

    assign hit       = valid_bits[index] && (tag_array[index] == tag);
    assign dirty     = valid_bits[index] && dirty_bits[index]; // victim needs write-back
    assign load_data = data_array[index];
    assign wb_data   = data_array[index];
    assign wb_addr   = {tag_array[index], index, {`MIPS_OFFSET_W{1'b0}}};

    assign store_en = cache_store && mem_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (cache_fill) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0; // fresh copy of memory
        end else if (store_en) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cache_fill) begin
            data_array[index] <= mem_rdata;
            tag_array[index]  <= tag;
        end else if (store_en) begin
            data_array[index] <= store_data;
        end
    end

    a_fill_store_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(cache_fill && cache_store)
    ) else $error("refill and store hit the cache in the same cycle");

endmodule

// ==== cache_cu.sv ====
`timescale 1ns/100ps
`include "mips_config.svh"

module cache_cu (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  hit,
    input  logic                  dirty,
    input  logic [`MIPS_XLEN-1:0] addr,
    input  logic [`MIPS_XLEN-1:0] wb_addr,
    input  logic [`MIPS_XLEN-1:0] wb_data,
    input  logic [`MIPS_XLEN-1:0] mem_rdata,
    input  logic                  mem_ack,
    output logic                  stall,
    output logic                  cache_fill,
    output logic                  cache_store,
    output logic [`MIPS_XLEN-1:0] mem_addr,
    output logic [`MIPS_XLEN-1:0] mem_wdata,
    output logic                  mem_we,
    output logic                  mem_req
);

    localparam logic [2:0] s_idle   = 3'd0;
    localparam logic [2:0] s_wb_req = 3'd1;
    localparam logic [2:0] s_wb_rel = 3'd2;
    localparam logic [2:0] s_rf_req = 3'd3;
    localparam logic [2:0] s_rf_rel = 3'd4;
    localparam logic [2:0] s_fill   = 3'd5;

    logic [2:0] state;
    logic       miss;

    assign miss = (mem_read || mem_write) && !hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:   if (miss) state <= dirty ? s_wb_req : s_rf_req;
                s_wb_req: if (mem_ack) state <= s_wb_rel;
                s_wb_rel: if (!mem_ack) state <= s_rf_req;
                s_rf_req: if (mem_ack) state <= s_fill;
                s_fill:   state <= s_rf_rel; // req still up, read data valid
                s_rf_rel: if (!mem_ack) state <= s_idle;
                default:  state <= s_idle;
            endcase
        end
    end

    assign stall       = (state != s_idle) || miss;
    assign cache_store = (state == s_idle) && mem_write && hit;
    assign cache_fill  = (state == s_fill);

    assign mem_req   = (state == s_wb_req) || (state == s_rf_req) || (state == s_fill);
    assign mem_we    = (state == s_wb_req);
    assign mem_wdata = wb_data;
    assign mem_addr  = (state == s_wb_req || state == s_wb_rel) ? wb_addr
                     : {addr[`MIPS_XLEN-1:`MIPS_OFFSET_W], {`MIPS_OFFSET_W{1'b0}}};

    a_req_held_until_ack: assert property (
        @(posedge clk) disable iff (reset) mem_req && !mem_ack |=> mem_req
    ) else $error("memory request withdrawn before acknowledge");

    a_fill_data_known: assert property (
        @(posedge clk) disable iff (reset) cache_fill |-> !$isunknown(mem_rdata)
    ) else $error("refill data from memory is unknown");

endmodule

// ==== mips_core.sv ====
`timescale 1ns/100ps
`include "mips_config.svh"

module mips_core (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`MIPS_XLEN-1:0] inst_addr,
    input  logic [`MIPS_XLEN-1:0] inst,
    output logic [`MIPS_XLEN-1:0] mem_addr,
    output logic [`MIPS_XLEN-1:0] mem_wdata,
    input  logic [`MIPS_XLEN-1:0] mem_rdata,
    output logic                  mem_we,
    output logic                  mem_req,
    input  logic                  mem_ack,
    output logic                  halted
);

    mips_pkg::alu_op_e     alu_op;
    logic                  alu_src;
    logic                  reg_dest;
    logic                  reg_write;
    logic                  mem_to_reg;
    logic                  branch_eq;
    logic                  branch_ne;
    logic                  jump;
    logic                  mem_read;
    logic                  mem_write;
    logic                  halt;
    logic                  stall;
    logic                  hit;
    logic                  dirty;
    logic                  cache_fill;
    logic                  cache_store;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic [`MIPS_XLEN-1:0] store_data;
    logic [`MIPS_XLEN-1:0] load_data;
    logic [`MIPS_XLEN-1:0] wb_addr;
    logic [`MIPS_XLEN-1:0] wb_data;

    data_path data_path_i (
        .clk(clk), .reset(reset), .inst(inst), .alu_op(alu_op),
        .alu_src(alu_src), .reg_dest(reg_dest), .reg_write(reg_write),
        .mem_to_reg(mem_to_reg), .branch_eq(branch_eq), .branch_ne(branch_ne),
        .jump(jump), .halt(halt), .stall(stall), .load_data(load_data),
        .inst_addr(inst_addr), .alu_result(alu_result), .store_data(store_data),
        .halted(halted)
    );

    control_unit control_unit_i (
        .inst(inst), .alu_op(alu_op), .alu_src(alu_src), .reg_dest(reg_dest),
        .reg_write(reg_write), .mem_to_reg(mem_to_reg), .branch_eq(branch_eq),
        .branch_ne(branch_ne), .jump(jump), .mem_read(mem_read),
        .mem_write(mem_write), .halt(halt)
    );

    memory_datapath memory_datapath_i (
        .clk(clk), .reset(reset), .addr(alu_result), .store_data(store_data),
        .mem_write(mem_write), .cache_fill(cache_fill), .cache_store(cache_store),
        .mem_rdata(mem_rdata), .load_data(load_data), .hit(hit), .dirty(dirty),
        .wb_addr(wb_addr), .wb_data(wb_data)
    );

    cache_cu cache_cu_i (
        .clk(clk), .reset(reset), .mem_read(mem_read), .mem_write(mem_write),
        .hit(hit), .dirty(dirty), .addr(alu_result), .wb_addr(wb_addr),
        .wb_data(wb_data), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
        .stall(stall), .cache_fill(cache_fill), .cache_store(cache_store),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
        .mem_req(mem_req)
    );

endmodule

// ==== tb_mips_core.sv ====
`timescale 1ns/100ps
`include "mips_config.svh"

module tb_mips_core;

    localparam int m_idle    = 0;
    localparam int m_wait    = 1;
    localparam int m_ack     = 2;
    localparam int m_release = 3;

    logic                  clk;
    logic                  reset = 1'b1;
    logic [`MIPS_XLEN-1:0] inst_addr;
    logic [`MIPS_XLEN-1:0] inst;
    logic [`MIPS_XLEN-1:0] mem_addr;
    logic [`MIPS_XLEN-1:0] mem_wdata;
    logic [`MIPS_XLEN-1:0] mem_rdata = '0;
    logic                  mem_we;
    logic                  mem_req;
    logic                  mem_ack = 1'b0;
    logic                  halted;

    logic [31:0] input_words [0:127];
    logic [31:0] rom         [0:63];
    logic [31:0] dmem        [0:255];
    logic [31:0] exp_addr    [0:31];
    logic [31:0] exp_data    [0:31];
    logic [31:0] lcg_state = 32'hd54b_b35e;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        req_we;
    int          prog_len;
    int          exp_count;
    int          check_errors = 0;
    int          protocol_errors = 0;
    int          phase = m_idle;
    int          wait_left;

    mips_core mips_core_i (
        .clk(clk), .reset(reset), .inst_addr(inst_addr), .inst(inst),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_we(mem_we), .mem_req(mem_req), .mem_ack(mem_ack), .halted(halted)
    );

    assign inst = rom[inst_addr[7:2]]; // combinational fetch

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, want);
            check_errors++;
        end
    endtask

    task automatic report_protocol(input string what);
        $display("memory protocol error at %0t: %s", $time, what);
        protocol_errors++;
    endtask

    task automatic load_input_file();
        int pos;
        int count;
        int k;
        $readmemh("test_input.txt", input_words);
        for (k = 0; k < 64; k++)
            rom[k] = {`MIPS_OP_HALT, 26'(k * 4)}; // halt words past the program
        for (k = 0; k < 256; k++)
            dmem[k] = 32'h5a5a_0000 ^ (k * 4);
        prog_len = input_words[0];
        for (k = 0; k < prog_len; k++)
            rom[k] = input_words[1 + k];
        pos = 1 + prog_len;
        count = input_words[pos];
        pos++;
        for (k = 0; k < count; k++)
            dmem[input_words[pos + 2 * k][9:2]] = input_words[pos + 2 * k + 1];
        pos = pos + 2 * count;
        exp_count = input_words[pos];
        pos++;
        for (k = 0; k < exp_count; k++) begin
            exp_addr[k] = input_words[pos + 2 * k];
            exp_data[k] = input_words[pos + 2 * k + 1];
        end
    endtask

    // data memory with random ack delay on both edges of the handshake
    always @(posedge clk) begin
        if (reset) begin
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            phase = m_idle;
            wait_left = 0;
        end else begin
            case (phase)
                m_idle: if (mem_req) begin
                    req_addr  = mem_addr;
                    req_we    = mem_we;
                    req_wdata = mem_wdata;
                    wait_left = int'(lcg_next() >> 30);
                    phase = m_wait;
                end
                m_wait: begin
                    if (!mem_req || mem_addr != req_addr || mem_we != req_we
                        || (req_we && mem_wdata != req_wdata))
                        report_protocol("request changed before acknowledge");
                    if (wait_left == 0) begin
                        if (req_we)
                            dmem[req_addr[9:2]] = req_wdata;
                        else
                            mem_rdata <= dmem[req_addr[9:2]];
                        mem_ack <= 1'b1;
                        phase = m_ack;
                    end else begin
                        wait_left--;
                    end
                end
                m_ack: begin
                    if (!mem_req) begin
                        wait_left = int'(lcg_next() >> 30);
                        phase = m_release;
                    end else if (mem_addr != req_addr || mem_we != req_we
                                 || (req_we && mem_wdata != req_wdata)) begin
                        report_protocol("request changed while acknowledge was high");
                    end
                end
                default: begin
                    if (mem_req)
                        report_protocol("new request before acknowledge fell");
                    if (wait_left == 0) begin
                        mem_ack <= 1'b0;
                        phase = m_idle;
                    end else begin
                        wait_left--;
                    end
                end
            endcase
        end
    end

    initial begin
        int limit;
        @(posedge clk); // program length is known by now
        limit = prog_len * 40 + 200;
        repeat (limit) @(posedge clk);
        if (!halted)
            $display("timeout: halted never rose within %0d cycles", limit);
        else
            $display("timeout: checks after halt did not finish");
        $display("errors: %0d check, %0d protocol", check_errors, protocol_errors);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] halt_addr;
        int k;
        load_input_file();
        halt_addr = 32'((prog_len - 1) * 4); // halt is the last program word
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value({31'b0, mem_req}, 32'd0, "mem_req in reset");
        check_value({31'b0, mem_we}, 32'd0, "mem_we in reset");
        check_value({31'b0, halted}, 32'd0, "halted in reset");
        check_value(inst_addr, 32'd0, "inst_addr in reset");
        @(posedge clk);
        reset <= 1'b0; // tenth rising edge with reset high
        while (!halted)
            @(negedge clk);
        repeat (10) begin
            check_value(inst_addr, halt_addr, "inst_addr after halt");
            @(negedge clk);
        end
        check_value({31'b0, mem_req}, 32'd0, "mem_req after halt");
        for (k = 0; k < exp_count; k++)
            check_value(dmem[exp_addr[k][9:2]], exp_data[k],
                        $sformatf("memory word %h", exp_addr[k]));
        $display("errors: %0d check, %0d protocol", check_errors, protocol_errors);
        if (check_errors == 0 && protocol_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== test_input.txt ====
// program length, then instruction words; init count, then address/value pairs;
// expected count, then address/value pairs of the final data memory
26
20010007 2002fffd 00221820 00222022 00222824 00223025 0041382a
ac030000 ac040004 ac050008 ac06000c ac070010
8c080000 21090064 ac090014
10220001 ac010018 10210001 ac020018
14210001 ac02001c 14220001 ac01001c
08000019 ac010040
8c0a0020 8c0a0024 8c0a0028 8c0a002c 8c0a0030 8c0a0034 8c0a0038 8c0a003c
8c0a0000 214a0001 ac0a0020 8c0b0000
fc000000
// initial data words
3
20 11110020  24 11110024  40 600d0040
// expected data words
0b
00 00000004  04 0000000a  08 00000005  0c ffffffff
10 00000001  14 00000068  18 00000007  1c fffffffd
20 00000005  24 11110024  40 600d0040

// ==== compile.f ====
+incdir+.
mips_pkg.sv
control_unit.sv
data_path.sv
memory_datapath.sv
cache_cu.sv
mips_core.sv
tb_mips_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_mips_core
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
